/* src/adxl_pkg.sv */
package adxl_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [5:0]  reg_addr_t;
    typedef logic [3:0]  word_idx_t;
    typedef logic [31:0] axil_data_t;
    typedef logic [3:0]  axil_strb_t;

    // 0x1D-0x2A, 0x2C-0x2F, 0x31, 0x38
    localparam logic [63:0] WRITE_MASK = 64'h0102_F7FF_E000_0000;

    localparam reg_addr_t SCAN_LIMIT = 6'h39; // last register read back
    localparam byte_t READ_LENGTH = 8'd58;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    typedef enum logic [2:0] {
        IDLE,
        CHECK_DIRTY,
        SEND_ADDR,
        SEND_VALUE,
        NEXT_ADDR,
        SEND_READ_REQ,
        AWAIT_READ_DATA
    } seq_state_t;

endpackage

/* src/reg_ifs.sv */
`timescale 1ns/1ps

interface host_reg_if;
    logic                  wr_en;
    adxl_pkg::word_idx_t   wr_word;
    adxl_pkg::axil_data_t  wr_data;
    adxl_pkg::axil_strb_t  wr_strb;
    adxl_pkg::word_idx_t   rd_word;
    adxl_pkg::axil_data_t  rd_data;

    modport host (output wr_en, wr_word, wr_data, wr_strb, rd_word, input rd_data);
    modport bank (input wr_en, wr_word, wr_data, wr_strb, rd_word, output rd_data);
endinterface

interface bank_seq_if;
    adxl_pkg::reg_addr_t scan_addr;
    logic                clear_dirty;
    logic                update_done;
    logic                update_pending;
    logic                scan_dirty;
    adxl_pkg::byte_t     scan_value;
    logic                rx_en;
    adxl_pkg::reg_addr_t rx_addr;
    adxl_pkg::byte_t     rx_data;

    modport seq (
        output scan_addr, clear_dirty, update_done, rx_en, rx_addr, rx_data,
        input  update_pending, scan_dirty, scan_value
    );
    modport bank (
        input  scan_addr, clear_dirty, update_done, rx_en, rx_addr, rx_data,
        output update_pending, scan_dirty, scan_value
    );
endinterface

/* src/axil_slave.sv */
`timescale 1ns/1ps

module axil_slave (
    input  logic                 S_AXI_LITE_ACLK,
    input  logic                 S_AXI_LITE_ARESETN,
    input  adxl_pkg::reg_addr_t  s_axi_lite_awaddr,
    input  logic                 s_axi_lite_awvalid,
    output logic                 s_axi_lite_awready,
    input  adxl_pkg::axil_data_t s_axi_lite_wdata,
    input  adxl_pkg::axil_strb_t s_axi_lite_wstrb,
    input  logic                 s_axi_lite_wvalid,
    output logic                 s_axi_lite_wready,
    output logic [1:0]           s_axi_lite_bresp,
    output logic                 s_axi_lite_bvalid,
    input  logic                 s_axi_lite_bready,
    input  adxl_pkg::reg_addr_t  s_axi_lite_araddr,
    input  logic                 s_axi_lite_arvalid,
    output logic                 s_axi_lite_arready,
    output adxl_pkg::axil_data_t s_axi_lite_rdata,
    output logic [1:0]           s_axi_lite_rresp,
    output logic                 s_axi_lite_rvalid,
    input  logic                 s_axi_lite_rready,
    host_reg_if.host             regs
);

    logic aw_en; // no write response outstanding
    logic wr_accept;
    logic rd_accept;

    assign wr_accept = !s_axi_lite_awready && s_axi_lite_awvalid && s_axi_lite_wvalid && aw_en;
    assign rd_accept = !s_axi_lite_arready && s_axi_lite_arvalid && !s_axi_lite_rvalid;

    assign regs.wr_en = s_axi_lite_awready && s_axi_lite_awvalid
                        && s_axi_lite_wready && s_axi_lite_wvalid;
    assign regs.wr_word = s_axi_lite_awaddr[5:2]; // byte address to word
    assign regs.wr_data = s_axi_lite_wdata;
    assign regs.wr_strb = s_axi_lite_wstrb;

    assign s_axi_lite_bresp = adxl_pkg::RESP_OKAY;
    assign s_axi_lite_rresp = adxl_pkg::RESP_OKAY;

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            s_axi_lite_awready <= 1'b0;
            s_axi_lite_wready  <= 1'b0;
            s_axi_lite_bvalid  <= 1'b0;
            aw_en              <= 1'b1;
        end else begin
            s_axi_lite_awready <= wr_accept; // single-cycle ready pulse
            s_axi_lite_wready  <= wr_accept;
            if (wr_accept) begin
                aw_en <= 1'b0;
            end else if (s_axi_lite_bvalid && s_axi_lite_bready) begin
                aw_en <= 1'b1;
            end
            if (regs.wr_en) begin
                s_axi_lite_bvalid <= 1'b1;
            end else if (s_axi_lite_bready) begin
                s_axi_lite_bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            s_axi_lite_arready <= 1'b0;
            s_axi_lite_rvalid  <= 1'b0;
        end else begin
            s_axi_lite_arready <= rd_accept;
            if (s_axi_lite_arready && s_axi_lite_arvalid) begin
                s_axi_lite_rvalid <= 1'b1;
            end else if (s_axi_lite_rready) begin
                s_axi_lite_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (rd_accept) begin
            regs.rd_word <= s_axi_lite_araddr[5:2];
        end
        if (s_axi_lite_arready && s_axi_lite_arvalid) begin
            s_axi_lite_rdata <= regs.rd_data;
        end
    end

    // a second write is never taken while its response waits
    assert property (@(posedge S_AXI_LITE_ACLK) disable iff (!S_AXI_LITE_ARESETN)
        regs.wr_en |-> !s_axi_lite_bvalid)
        else $error("write accepted with BVALID high");

    // read data held until taken
    assert property (@(posedge S_AXI_LITE_ACLK) disable iff (!S_AXI_LITE_ARESETN)
        s_axi_lite_rvalid && !s_axi_lite_rready
        |=> s_axi_lite_rvalid && $stable(s_axi_lite_rdata))
        else $error("RVALID or RDATA changed before RREADY");

endmodule

/* src/adxl_reg_bank.sv */
`timescale 1ns/1ps

module adxl_reg_bank (
    input  logic      S_AXI_LITE_ACLK,
    input  logic      S_AXI_LITE_ARESETN,
    host_reg_if.bank  host,
    bank_seq_if.bank  seq
);

    adxl_pkg::byte_t [63:0] map; // register shadow
    logic [63:0] dirty;
    logic [63:0] host_hit;       // bytes written by the host this cycle
    logic [63:0] rx_hit;
    logic [63:0] clr_hit;
    logic        pending;

    always_comb begin
        host_hit = '0;
        for (int b = 0; b < 4; b++) begin
            if (host.wr_en && host.wr_strb[b]) begin
                host_hit[4 * host.wr_word + b] = 1'b1;
            end
        end
        host_hit &= adxl_pkg::WRITE_MASK; // read-only bytes dropped
    end

    assign rx_hit  = seq.rx_en ? (64'd1 << seq.rx_addr) : '0;
    assign clr_hit = seq.clear_dirty ? (64'd1 << seq.scan_addr) : '0;

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            map     <= '0;
            dirty   <= '0;
            pending <= 1'b0;
        end else begin
            for (int i = 0; i < 64; i++) begin
                if (host_hit[i]) begin
                    map[i]   <= host.wr_data[8 * (i % 4) +: 8];
                    dirty[i] <= 1'b1;
                end else begin
                    if (rx_hit[i]) begin
                        map[i] <= seq.rx_data; // host wins on a clash
                    end
                    if (clr_hit[i]) begin
                        dirty[i] <= 1'b0;
                    end
                end
            end
            if (|host_hit) begin
                pending <= 1'b1;
            end else if (seq.update_done) begin
                pending <= 1'b0;
            end
        end
    end

    assign host.rd_data       = map[{host.rd_word, 2'b00} +: 4];
    assign seq.update_pending = pending;
    assign seq.scan_dirty     = dirty[seq.scan_addr];
    assign seq.scan_value     = map[seq.scan_addr];

    // a reply longer than the map would wrap the address
    assert property (@(posedge S_AXI_LITE_ACLK) disable iff (!S_AXI_LITE_ARESETN)
        seq.rx_en |-> seq.rx_addr <= adxl_pkg::SCAN_LIMIT)
        else $error("stream byte beyond scan limit");

endmodule

/* src/adxl_sequencer.sv */
`timescale 1ns/1ps

module adxl_sequencer #(
    parameter logic [6:0] DEVICE_ADDRESS   = 7'h53,
    parameter int         REQUEST_INTERVAL = 1000
) (
    input  logic            S_AXI_LITE_ACLK,
    input  logic            S_AXI_LITE_ARESETN,
    bank_seq_if.seq         bank,
    output logic            push,
    output adxl_pkg::byte_t push_data,
    output adxl_pkg::byte_t push_user,
    output logic            push_last,
    input  logic            almost_full,
    input  adxl_pkg::byte_t s_axis_tdata,
    input  logic            s_axis_tvalid,
    input  logic            s_axis_tlast
);

    localparam int TW = $clog2(REQUEST_INTERVAL + 1);
    localparam logic [TW-1:0] TIMER_LAST = TW'(REQUEST_INTERVAL - 1);

    adxl_pkg::seq_state_t state;
    adxl_pkg::reg_addr_t  addr;
    logic [TW-1:0]        timer;

    assign bank.scan_addr = addr;
    assign bank.rx_addr   = addr;
    assign bank.rx_data   = s_axis_tdata;
    assign bank.rx_en     = (state == adxl_pkg::AWAIT_READ_DATA) && s_axis_tvalid;

    always_comb begin
        push             = 1'b0;
        push_data        = {2'b00, addr}; // register address byte
        push_user        = {DEVICE_ADDRESS, 1'b0};
        push_last        = 1'b0;
        bank.clear_dirty = 1'b0;
        bank.update_done = 1'b0;
        case (state)
            adxl_pkg::SEND_ADDR: begin
                push = !almost_full;
            end
            adxl_pkg::SEND_VALUE: begin
                push             = !almost_full;
                push_data        = bank.scan_value;
                push_last        = 1'b1;
                bank.clear_dirty = !almost_full;
            end
            adxl_pkg::NEXT_ADDR: begin
                bank.update_done = (addr == adxl_pkg::SCAN_LIMIT);
            end
            adxl_pkg::SEND_READ_REQ: begin
                push      = !almost_full;
                push_data = adxl_pkg::READ_LENGTH;
                push_user = {DEVICE_ADDRESS, 1'b1}; // read flag
                push_last = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            state <= adxl_pkg::IDLE;
            addr  <= '0;
            timer <= '0;
        end else begin
            case (state)
                adxl_pkg::IDLE: begin
                    if (bank.update_pending) begin
                        state <= adxl_pkg::CHECK_DIRTY;
                        addr  <= '0;
                    end else if (timer == TIMER_LAST) begin
                        state <= adxl_pkg::SEND_READ_REQ;
                    end else begin
                        timer <= timer + 1'b1;
                    end
                end
                adxl_pkg::CHECK_DIRTY: begin
                    state <= bank.scan_dirty ? adxl_pkg::SEND_ADDR : adxl_pkg::NEXT_ADDR;
                end
                adxl_pkg::SEND_ADDR: begin
                    if (!almost_full) state <= adxl_pkg::SEND_VALUE;
                end
                adxl_pkg::SEND_VALUE: begin
                    if (!almost_full) state <= adxl_pkg::NEXT_ADDR;
                end
                adxl_pkg::NEXT_ADDR: begin
                    if (addr == adxl_pkg::SCAN_LIMIT) begin
                        state <= adxl_pkg::IDLE;
                    end else begin
                        addr  <= addr + 1'b1;
                        state <= adxl_pkg::CHECK_DIRTY;
                    end
                end
                adxl_pkg::SEND_READ_REQ: begin
                    if (!almost_full) begin
                        state <= adxl_pkg::AWAIT_READ_DATA;
                        addr  <= '0; // reply starts at register 0
                    end
                end
                adxl_pkg::AWAIT_READ_DATA: begin
                    if (s_axis_tvalid) begin
                        addr <= addr + 1'b1;
                        if (s_axis_tlast) begin
                            state <= adxl_pkg::IDLE;
                            timer <= '0;
                        end
                    end
                end
                default: state <= adxl_pkg::IDLE;
            endcase
        end
    end

    // only a byte found dirty is ever cleared
    assert property (@(posedge S_AXI_LITE_ACLK) disable iff (!S_AXI_LITE_ARESETN)
        bank.clear_dirty |-> bank.scan_dirty)
        else $error("dirty flag cleared on a clean byte");

endmodule

/* src/cmd_fifo.sv */
`timescale 1ns/1ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic            S_AXI_LITE_ACLK,
    input  logic            S_AXI_LITE_ARESETN,
    input  logic            push,
    input  adxl_pkg::byte_t push_data,
    input  adxl_pkg::byte_t push_user,
    input  logic            push_last,
    output logic            almost_full,
    output adxl_pkg::byte_t m_axis_tdata,
    output adxl_pkg::byte_t m_axis_tuser,
    output logic            m_axis_tvalid,
    output logic            m_axis_tlast,
    input  logic            m_axis_tready
);

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    logic [16:0]   mem [FIFO_DEPTH]; // {last, user, data}
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic          pop;

    assign pop = m_axis_tvalid && m_axis_tready;
    assign m_axis_tvalid = (count != '0);
    assign {m_axis_tlast, m_axis_tuser, m_axis_tdata} = mem[rd_ptr]; // show-ahead head
    assign almost_full = (count >= CW'(FIFO_DEPTH - 2));

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (push) mem[wr_ptr] <= {push_last, push_user, push_data};
    end

    always_ff @(posedge S_AXI_LITE_ACLK) begin
        if (!S_AXI_LITE_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    assert property (@(posedge S_AXI_LITE_ACLK) disable iff (!S_AXI_LITE_ARESETN)
        push |-> count != CW'(FIFO_DEPTH))
        else $error("push into full FIFO");

endmodule

/* src/axi_adxl345.sv */
`timescale 1ns/1ps

module axi_adxl345 #(
    parameter logic [6:0] DEVICE_ADDRESS   = 7'h53,
    parameter int         REQUEST_INTERVAL = 1000,
    parameter int         FIFO_DEPTH       = 16
) (
    input  logic                 S_AXI_LITE_ACLK,
    input  logic                 S_AXI_LITE_ARESETN,
    input  adxl_pkg::reg_addr_t  s_axi_lite_awaddr,
    input  logic                 s_axi_lite_awvalid,
    output logic                 s_axi_lite_awready,
    input  adxl_pkg::axil_data_t s_axi_lite_wdata,
    input  adxl_pkg::axil_strb_t s_axi_lite_wstrb,
    input  logic                 s_axi_lite_wvalid,
    output logic                 s_axi_lite_wready,
    output logic [1:0]           s_axi_lite_bresp,
    output logic                 s_axi_lite_bvalid,
    input  logic                 s_axi_lite_bready,
    input  adxl_pkg::reg_addr_t  s_axi_lite_araddr,
    input  logic                 s_axi_lite_arvalid,
    output logic                 s_axi_lite_arready,
    output adxl_pkg::axil_data_t s_axi_lite_rdata,
    output logic [1:0]           s_axi_lite_rresp,
    output logic                 s_axi_lite_rvalid,
    input  logic                 s_axi_lite_rready,
    output adxl_pkg::byte_t      m_axis_tdata,
    output adxl_pkg::byte_t      m_axis_tuser,
    output logic                 m_axis_tvalid,
    output logic                 m_axis_tlast,
    input  logic                 m_axis_tready,
    input  adxl_pkg::byte_t      s_axis_tdata,
    input  logic                 s_axis_tvalid,
    input  logic                 s_axis_tlast
);

    logic            push;
    adxl_pkg::byte_t push_data;
    adxl_pkg::byte_t push_user;
    logic            push_last;
    logic            almost_full;

    host_reg_if host_bus ();
    bank_seq_if seq_bus ();

    axil_slave u_axil_slave (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .s_axi_lite_awaddr  (s_axi_lite_awaddr),
        .s_axi_lite_awvalid (s_axi_lite_awvalid),
        .s_axi_lite_awready (s_axi_lite_awready),
        .s_axi_lite_wdata   (s_axi_lite_wdata),
        .s_axi_lite_wstrb   (s_axi_lite_wstrb),
        .s_axi_lite_wvalid  (s_axi_lite_wvalid),
        .s_axi_lite_wready  (s_axi_lite_wready),
        .s_axi_lite_bresp   (s_axi_lite_bresp),
        .s_axi_lite_bvalid  (s_axi_lite_bvalid),
        .s_axi_lite_bready  (s_axi_lite_bready),
        .s_axi_lite_araddr  (s_axi_lite_araddr),
        .s_axi_lite_arvalid (s_axi_lite_arvalid),
        .s_axi_lite_arready (s_axi_lite_arready),
        .s_axi_lite_rdata   (s_axi_lite_rdata),
        .s_axi_lite_rresp   (s_axi_lite_rresp),
        .s_axi_lite_rvalid  (s_axi_lite_rvalid),
        .s_axi_lite_rready  (s_axi_lite_rready),
        .regs               (host_bus.host)
    );

    adxl_reg_bank u_reg_bank (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .host               (host_bus.bank),
        .seq                (seq_bus.bank)
    );

    adxl_sequencer #(
        .DEVICE_ADDRESS   (DEVICE_ADDRESS),
        .REQUEST_INTERVAL (REQUEST_INTERVAL)
    ) u_sequencer (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .bank               (seq_bus.seq),
        .push               (push),
        .push_data          (push_data),
        .push_user          (push_user),
        .push_last          (push_last),
        .almost_full        (almost_full),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tlast       (s_axis_tlast)
    );

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_cmd_fifo (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .push               (push),
        .push_data          (push_data),
        .push_user          (push_user),
        .push_last          (push_last),
        .almost_full        (almost_full),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tuser       (m_axis_tuser),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_tready      (m_axis_tready)
    );

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

endmodule

/* sim/tb_axi_adxl345.sv */
`timescale 1ns/1ps

module tb_axi_adxl345;

    localparam int REQ_INTERVAL = 300;
    localparam int ROUNDS       = 6;
    localparam int REPLY_LEN    = 58;                 // registers 0x00 to 0x39
    localparam logic [7:0] CMD_USER  = {7'h53, 1'b0};
    localparam logic [7:0] READ_USER = {7'h53, 1'b1};
    localparam logic [8:0] REQ_BEAT  = {1'b1, 8'd58}; // {last, data}
    // timer wait, host traffic, reply and throttled scan in each round
    localparam int MAX_CYCLES = 20 + ROUNDS * (REQ_INTERVAL + 1200);

    logic        S_AXI_LITE_ACLK;
    logic        S_AXI_LITE_ARESETN;
    logic [5:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [5:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [7:0]  m_tdata;
    logic [7:0]  m_tuser;
    logic        m_tvalid;
    logic        m_tlast;
    logic        m_tready;
    logic [7:0]  s_tdata;
    logic        s_tvalid;
    logic        s_tlast;

    logic [7:0]  exp_map [64];   // expected register shadow
    logic        exp_dirty [64];
    logic [8:0]  exp_cmds [$];   // {last, data}
    int          errors;
    int          checks;
    int          cycles;
    int          req_count;
    logic        reply_go;
    logic        reply_done;
    logic        throttle;
    logic [31:0] main_rng;
    logic [31:0] chip_rng;
    logic [31:0] ready_rng;

    tb_clock #(.PERIOD_NS(100)) u_clock (.clk(S_AXI_LITE_ACLK));

    axi_adxl345 #(
        .REQUEST_INTERVAL (REQ_INTERVAL)
    ) uut (
        .S_AXI_LITE_ACLK    (S_AXI_LITE_ACLK),
        .S_AXI_LITE_ARESETN (S_AXI_LITE_ARESETN),
        .s_axi_lite_awaddr  (awaddr),
        .s_axi_lite_awvalid (awvalid),
        .s_axi_lite_awready (awready),
        .s_axi_lite_wdata   (wdata),
        .s_axi_lite_wstrb   (wstrb),
        .s_axi_lite_wvalid  (wvalid),
        .s_axi_lite_wready  (wready),
        .s_axi_lite_bresp   (bresp),
        .s_axi_lite_bvalid  (bvalid),
        .s_axi_lite_bready  (bready),
        .s_axi_lite_araddr  (araddr),
        .s_axi_lite_arvalid (arvalid),
        .s_axi_lite_arready (arready),
        .s_axi_lite_rdata   (rdata),
        .s_axi_lite_rresp   (rresp),
        .s_axi_lite_rvalid  (rvalid),
        .s_axi_lite_rready  (rready),
        .m_axis_tdata       (m_tdata),
        .m_axis_tuser       (m_tuser),
        .m_axis_tvalid      (m_tvalid),
        .m_axis_tlast       (m_tlast),
        .m_axis_tready      (m_tready),
        .s_axis_tdata       (s_tdata),
        .s_axis_tvalid      (s_tvalid),
        .s_axis_tlast       (s_tlast)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // host-writable registers of the chip
    function automatic logic writable(input int a);
        return (a >= 'h1D && a <= 'h2A) || (a >= 'h2C && a <= 'h2F) || a == 'h31 || a == 'h38;
    endfunction

    task automatic write_word(input int w, input logic [31:0] data, input logic [3:0] strb);
        @(negedge S_AXI_LITE_ACLK);
        awaddr  = 6'(4 * w);
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = 1'b1;
        do @(posedge S_AXI_LITE_ACLK); while (!awready);
        checks++;
        if (wready !== 1'b1) begin
            errors++;
            $display("WREADY did not pulse together with AWREADY on word %0d", w);
        end
        @(negedge S_AXI_LITE_ACLK);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge S_AXI_LITE_ACLK); while (!bvalid);
        checks++;
        if (bresp !== 2'b00) begin
            errors++;
            $display("Error masked_write bresp: expected %h, actual %h", 2'b00, bresp);
        end
        @(negedge S_AXI_LITE_ACLK);
        bready = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (strb[b] && writable(4 * w + b)) begin
                exp_map[4 * w + b]   = data[8 * b +: 8];
                exp_dirty[4 * w + b] = 1'b1;
            end
        end
    endtask

    task automatic read_word(input string test, input int w, output logic [31:0] data);
        @(negedge S_AXI_LITE_ACLK);
        araddr  = 6'(4 * w);
        arvalid = 1'b1;
        rready  = 1'b1;
        do @(posedge S_AXI_LITE_ACLK); while (!arready);
        @(negedge S_AXI_LITE_ACLK);
        arvalid = 1'b0;
        do @(posedge S_AXI_LITE_ACLK); while (!rvalid);
        data = rdata;
        checks++;
        if (rresp !== 2'b00) begin
            errors++;
            $display("Error %s rresp word %0d: expected %h, actual %h", test, w, 2'b00, rresp);
        end
        @(negedge S_AXI_LITE_ACLK);
        rready = 1'b0;
    endtask

    task automatic check_all_words(input string test);
        logic [31:0] got;
        logic [31:0] expected;
        for (int w = 0; w < 16; w++) begin
            read_word(test, w, got);
            expected = {exp_map[4 * w + 3], exp_map[4 * w + 2],
                        exp_map[4 * w + 1], exp_map[4 * w]};
            checks++;
            if (got !== expected) begin
                errors++;
                $display("Error %s word %0d: expected %h, actual %h", test, w, expected, got);
            end
        end
    endtask

    task automatic write_all_words();
        int start;
        logic [31:0] data;
        main_rng = xorshift(main_rng);
        start = main_rng % 16;
        for (int k = 0; k < 16; k++) begin
            main_rng = xorshift(main_rng);
            data = main_rng;
            main_rng = xorshift(main_rng);
            write_word((start + k) % 16, data, main_rng[3:0]);
        end
    endtask

    // one address/value pair per dirty byte in ascending order
    task automatic queue_updates();
        for (int a = 0; a < 64; a++) begin
            if (exp_dirty[a]) begin
                exp_cmds.push_back({1'b0, 8'(a)});
                exp_cmds.push_back({1'b1, exp_map[a]});
                exp_dirty[a] = 1'b0;
            end
        end
    endtask

    always @(negedge S_AXI_LITE_ACLK) begin
        ready_rng = xorshift(ready_rng);
        m_tready  = throttle ? ((ready_rng % 10) < 3) : 1'b1; // about 30 % when throttled
    end

    always @(posedge S_AXI_LITE_ACLK) begin
        if (S_AXI_LITE_ARESETN && m_tvalid && m_tready) begin
            if (m_tuser == READ_USER) begin
                checks++;
                if ({m_tlast, m_tdata} !== REQ_BEAT) begin
                    errors++;
                    $display("Error read_request: expected %h, actual %h",
                             REQ_BEAT, {m_tlast, m_tdata});
                end
                req_count++;
            end else if (m_tuser !== CMD_USER) begin
                errors++;
                $display("Error update_cmd tuser: expected %h, actual %h", CMD_USER, m_tuser);
            end else if (exp_cmds.size() == 0) begin
                errors++;
                $display("unexpected command byte %h on M_AXIS", m_tdata);
            end else begin
                checks++;
                if ({m_tlast, m_tdata} !== exp_cmds[0]) begin
                    errors++;
                    $display("Error update_cmd: expected %h, actual %h",
                             exp_cmds[0], {m_tlast, m_tdata});
                end
                void'(exp_cmds.pop_front());
            end
        end
    end

    // chip responder answering a read request once released
    initial begin : chip_responder
        logic [7:0] value;
        forever begin
            @(negedge S_AXI_LITE_ACLK);
            if (reply_go) begin
                reply_go = 1'b0;
                chip_rng = xorshift(chip_rng);
                repeat (chip_rng % 16) @(negedge S_AXI_LITE_ACLK);
                for (int i = 0; i < REPLY_LEN; i++) begin
                    chip_rng = xorshift(chip_rng);
                    if (chip_rng[31:30] == 2'b00) begin
                        s_tvalid = 1'b0; // idle beat
                        @(negedge S_AXI_LITE_ACLK);
                    end
                    value    = chip_rng[7:0];
                    s_tdata  = value;
                    s_tvalid = 1'b1;
                    s_tlast  = (i == REPLY_LEN - 1);
                    exp_map[i] = value;
                    @(negedge S_AXI_LITE_ACLK);
                end
                s_tvalid = 1'b0;
                s_tlast  = 1'b0;
                queue_updates();
                reply_done = 1'b1;
            end
        end
    end

    always @(posedge S_AXI_LITE_ACLK) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles waiting for the DUT", cycles);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin
        S_AXI_LITE_ARESETN = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        m_tready   = 1'b1;
        s_tdata    = '0;
        s_tvalid   = 1'b0;
        s_tlast    = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        req_count  = 0;
        reply_go   = 1'b0;
        reply_done = 1'b0;
        throttle   = 1'b0;
        main_rng   = 32'd93;
        chip_rng   = 32'd93 * 7; // separate streams from seed 93
        ready_rng  = 32'd93 * 13;
        for (int a = 0; a < 64; a++) begin
            exp_map[a]   = 8'h00;
            exp_dirty[a] = 1'b0;
        end
        repeat (10) @(posedge S_AXI_LITE_ACLK);
        @(negedge S_AXI_LITE_ACLK);
        S_AXI_LITE_ARESETN = 1'b1;

        check_all_words("reset");
        checks++;
        if (m_tvalid !== 1'b0) begin
            errors++;
            $display("M_AXIS_TVALID went high before the first timer read");
        end

        for (int r = 0; r < ROUNDS; r++) begin
            throttle = (r >= ROUNDS / 2);
            while (req_count == 0) @(negedge S_AXI_LITE_ACLK);
            req_count--;
            if (r % 3 != 0) begin
                write_all_words(); // DUT waits on the reply, so the scan starts after it
                check_all_words("masked_write");
            end
            reply_done = 1'b0;
            reply_go   = 1'b1;
            while (!reply_done) @(negedge S_AXI_LITE_ACLK);
            while (exp_cmds.size() != 0) @(negedge S_AXI_LITE_ACLK);
            check_all_words("periodic_read");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
src/adxl_pkg.sv
src/reg_ifs.sv
src/axil_slave.sv
src/adxl_reg_bank.sv
src/adxl_sequencer.sv
src/cmd_fifo.sv
src/axi_adxl345.sv
sim/tb_clock.sv
sim/tb_axi_adxl345.sv

/* Bender.yml */
package:
  name: axi_adxl345

sources:
  - files:
      - src/adxl_pkg.sv
      - src/reg_ifs.sv
      - src/axil_slave.sv
      - src/adxl_reg_bank.sv
      - src/adxl_sequencer.sv
      - src/cmd_fifo.sv
      - src/axi_adxl345.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/tb_axi_adxl345.sv
